//--- rv_pkg.sv
/*
 Shared definitions for the RV32I core
 Word and register index types, opcodes, funct3 codes, ALU and fetch enums
*/
package rv_pkg;

    // Data, address and instruction word
    typedef logic [31:0] rv_word;
    // Architectural register index
    typedef logic [4:0] rv_reg_id;
    // Major opcode field
    typedef logic [6:0] rv_opcode;
    // Minor function field
    typedef logic [2:0] rv_funct3;

    // Major opcodes of the kept subset
    localparam rv_opcode OP_REG    = 7'b0110011;
    localparam rv_opcode OP_IMM    = 7'b0010011;
    localparam rv_opcode OP_LUI    = 7'b0110111;
    localparam rv_opcode OP_LOAD   = 7'b0000011;
    localparam rv_opcode OP_STORE  = 7'b0100011;
    localparam rv_opcode OP_BRANCH = 7'b1100011;
    localparam rv_opcode OP_JAL    = 7'b1101111;

    // funct3 codes, ALU group
    localparam rv_funct3 F3_ADD  = 3'b000;
    localparam rv_funct3 F3_SLT  = 3'b010;
    localparam rv_funct3 F3_XOR  = 3'b100;
    localparam rv_funct3 F3_OR   = 3'b110;
    localparam rv_funct3 F3_AND  = 3'b111;
    // funct3 codes, memory and branch group
    localparam rv_funct3 F3_WORD = 3'b010;
    localparam rv_funct3 F3_BEQ  = 3'b000;
    localparam rv_funct3 F3_BNE  = 3'b001;

    // ALU operations, PASS_B forwards operand b for LUI
    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_PASS_B
    } rv_alu_op;

    // Address of the first fetch
    localparam rv_word RESET_PC = 32'h0000_0000;
    // Destination of a slot that writes nothing
    localparam rv_reg_id NOP_ID = 5'd0;

    // Fetch FSM, one request outstanding at most
    typedef enum logic {IDLE, WAIT} rv_fetch_state;

endpackage

//--- rv_regfile.sv
/*
 Integer register file, 32 x 32 bits
 Two combinational reads with write-through, one synchronous write
*/
`timescale 1ns/1ps

module rv_regfile (
    input  logic             clk,
    input  rv_pkg::rv_reg_id rs1,
    input  rv_pkg::rv_reg_id rs2,
    output rv_pkg::rv_word   rd1,
    output rv_pkg::rv_word   rd2,
    input  logic             wb_en,
    input  rv_pkg::rv_reg_id wb_rd,
    input  rv_pkg::rv_word   wb_data
);

    rv_pkg::rv_word regs [32];

    // x0 never stored
    always_ff @(posedge clk) begin
        if (wb_en && wb_rd != rv_pkg::NOP_ID)
            regs[wb_rd] <= wb_data;
    end

    // Same-cycle write is seen by decode
    assign rd1 = (rs1 == rv_pkg::NOP_ID) ? '0 :
                 (wb_en && wb_rd == rs1) ? wb_data : regs[rs1];
    assign rd2 = (rs2 == rv_pkg::NOP_ID) ? '0 :
                 (wb_en && wb_rd == rs2) ? wb_data : regs[rs2];

endmodule

//--- rv_fetch.sv
/*
 Fetch stage with PC, instruction request FSM,
 one-word skid buffer and the fetch/decode register
*/
`timescale 1ns/1ps

module rv_fetch (
    input  logic           clk,
    input  logic           resetn,
    output logic           instr_req,
    output rv_pkg::rv_word instr_addr,
    input  logic           instr_done,
    input  rv_pkg::rv_word instr_rdata,
    input  logic           hold,
    input  logic           redirect,
    input  rv_pkg::rv_word redirect_pc,
    output logic           fd_valid,
    output rv_pkg::rv_word fd_pc,
    output rv_pkg::rv_word fd_instr
);

    rv_pkg::rv_fetch_state state;
    rv_pkg::rv_word pc;
    rv_pkg::rv_word req_addr;
    rv_pkg::rv_word buf_pc;
    rv_pkg::rv_word buf_instr;
    logic drop;
    logic buf_valid;
    logic got;
    logic advance;

    // Address held stable while the request is open
    assign instr_req  = (state == rv_pkg::WAIT);
    assign instr_addr = req_addr;
    // Word returned for the current path
    assign got = instr_req && instr_done && !drop;
    // Fetch/decode slot free or being consumed
    assign advance = !fd_valid || !hold;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state     <= rv_pkg::IDLE;
            pc        <= rv_pkg::RESET_PC;
            drop      <= 1'b0;
            fd_valid  <= 1'b0;
            buf_valid <= 1'b0;
        end else begin
            case (state)
                // No new request while a word waits in the buffer
                rv_pkg::IDLE: if (redirect || !buf_valid) state <= rv_pkg::WAIT;
                rv_pkg::WAIT: begin
                    if (instr_done) begin
                        state <= rv_pkg::IDLE;
                        drop  <= 1'b0;
                    end else if (redirect) begin
                        // Outstanding word belongs to the old path
                        drop <= 1'b1;
                    end
                end
                default: state <= rv_pkg::IDLE;
            endcase
            if (redirect) begin
                pc        <= redirect_pc;
                fd_valid  <= 1'b0;
                buf_valid <= 1'b0;
            end else begin
                if (got)
                    pc <= pc + 32'd4;
                // Buffer is older than any new word
                if (advance) begin
                    fd_valid  <= buf_valid || got;
                    buf_valid <= 1'b0;
                end else if (got) begin
                    buf_valid <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == rv_pkg::IDLE)
            req_addr <= redirect ? redirect_pc : pc;
        if (advance) begin
            fd_pc    <= buf_valid ? buf_pc : req_addr;
            fd_instr <= buf_valid ? buf_instr : instr_rdata;
        end
        if (got) begin
            buf_pc    <= req_addr;
            buf_instr <= instr_rdata;
        end
    end

endmodule

//--- rv_decode.sv
/*
 Decode stage with field and immediate extraction, ALU select,
 read-after-write interlock and the decode/execute register
*/
`timescale 1ns/1ps

module rv_decode (
    input  logic             clk,
    input  logic             resetn,
    input  logic             fd_valid,
    input  rv_pkg::rv_word   fd_pc,
    input  rv_pkg::rv_word   fd_instr,
    input  logic             hold,
    input  logic             redirect,
    output rv_pkg::rv_reg_id rs1,
    output rv_pkg::rv_reg_id rs2,
    input  rv_pkg::rv_word   rd1,
    input  rv_pkg::rv_word   rd2,
    input  rv_pkg::rv_reg_id ex_rd,
    input  logic             ex_valid,
    input  rv_pkg::rv_reg_id wb_rd,
    input  logic             wb_en,
    output logic             dec_stall,
    output logic             de_valid,
    output rv_pkg::rv_word   de_pc,
    output rv_pkg::rv_opcode de_op,
    output rv_pkg::rv_alu_op de_alu_op,
    output rv_pkg::rv_word   de_a,
    output rv_pkg::rv_word   de_b,
    output rv_pkg::rv_word   de_imm,
    output rv_pkg::rv_reg_id de_rd,
    output rv_pkg::rv_word   de_store_data
);

    rv_pkg::rv_opcode opcode;
    rv_pkg::rv_opcode op;
    rv_pkg::rv_funct3 funct3;
    rv_pkg::rv_alu_op alu_op;
    rv_pkg::rv_reg_id dst;
    rv_pkg::rv_word imm_i;
    rv_pkg::rv_word imm_s;
    rv_pkg::rv_word imm_b;
    rv_pkg::rv_word imm_u;
    rv_pkg::rv_word imm_j;
    rv_pkg::rv_word opb;
    rv_pkg::rv_word imm;
    logic legal;
    logic use_rs1;
    logic use_rs2;
    logic hit1;
    logic hit2;
    logic issue;

    assign opcode = fd_instr[6:0];
    assign funct3 = fd_instr[14:12];
    assign rs1    = fd_instr[19:15];
    assign rs2    = fd_instr[24:20];
    // Immediates, sign taken from bit 31
    assign imm_i = {{20{fd_instr[31]}}, fd_instr[31:20]};
    assign imm_s = {{20{fd_instr[31]}}, fd_instr[31:25], fd_instr[11:7]};
    assign imm_b = {{19{fd_instr[31]}}, fd_instr[31], fd_instr[7], fd_instr[30:25],
                    fd_instr[11:8], 1'b0};
    assign imm_u = {fd_instr[31:12], 12'b0};
    assign imm_j = {{11{fd_instr[31]}}, fd_instr[31], fd_instr[19:12], fd_instr[20],
                    fd_instr[30:21], 1'b0};

    always_comb begin
        op      = opcode;
        alu_op  = rv_pkg::ALU_ADD;
        dst     = fd_instr[11:7];
        opb     = imm_i;
        imm     = imm_i;
        legal   = 1'b1;
        use_rs1 = 1'b1;
        use_rs2 = 1'b0;
        case (opcode)
            rv_pkg::OP_REG: begin
                use_rs2 = 1'b1;
                opb     = rd2;
                case (funct3)
                    rv_pkg::F3_ADD: begin
                        if (fd_instr[30])
                            alu_op = rv_pkg::ALU_SUB;
                    end
                    rv_pkg::F3_AND: alu_op = rv_pkg::ALU_AND;
                    rv_pkg::F3_OR:  alu_op = rv_pkg::ALU_OR;
                    rv_pkg::F3_XOR: alu_op = rv_pkg::ALU_XOR;
                    rv_pkg::F3_SLT: alu_op = rv_pkg::ALU_SLT;
                    default:        legal  = 1'b0;
                endcase
            end
            rv_pkg::OP_IMM: begin
                case (funct3)
                    rv_pkg::F3_ADD: alu_op = rv_pkg::ALU_ADD;
                    rv_pkg::F3_AND: alu_op = rv_pkg::ALU_AND;
                    rv_pkg::F3_OR:  alu_op = rv_pkg::ALU_OR;
                    rv_pkg::F3_XOR: alu_op = rv_pkg::ALU_XOR;
                    default:        legal  = 1'b0;
                endcase
            end
            rv_pkg::OP_LUI: begin
                use_rs1 = 1'b0;
                opb     = imm_u;
                alu_op  = rv_pkg::ALU_PASS_B;
            end
            // Word accesses only
            rv_pkg::OP_LOAD: legal = (funct3 == rv_pkg::F3_WORD);
            rv_pkg::OP_STORE: begin
                use_rs2 = 1'b1;
                opb     = imm_s;
                dst     = rv_pkg::NOP_ID;
                legal   = (funct3 == rv_pkg::F3_WORD);
            end
            // BEQ compares by SUB, BNE by XOR
            rv_pkg::OP_BRANCH: begin
                use_rs2 = 1'b1;
                opb     = rd2;
                imm     = imm_b;
                dst     = rv_pkg::NOP_ID;
                if (funct3 == rv_pkg::F3_BNE)
                    alu_op = rv_pkg::ALU_XOR;
                else if (funct3 == rv_pkg::F3_BEQ)
                    alu_op = rv_pkg::ALU_SUB;
                else
                    legal = 1'b0;
            end
            rv_pkg::OP_JAL: begin
                use_rs1 = 1'b0;
                imm     = imm_j;
            end
            default: legal = 1'b0;
        endcase
        // Unsupported encodings retire with no effect
        if (!legal) begin
            op      = '0;
            dst     = rv_pkg::NOP_ID;
            use_rs1 = 1'b0;
            use_rs2 = 1'b0;
        end
    end

    // Source pending in execute, or in result and not written this cycle
    assign hit1 = (rs1 != rv_pkg::NOP_ID) &&
                  ((de_valid && de_rd == rs1) ||
                   (ex_valid && ex_rd == rs1 && !(wb_en && wb_rd == rs1)));
    assign hit2 = (rs2 != rv_pkg::NOP_ID) &&
                  ((de_valid && de_rd == rs2) ||
                   (ex_valid && ex_rd == rs2 && !(wb_en && wb_rd == rs2)));
    assign dec_stall = fd_valid && ((use_rs1 && hit1) || (use_rs2 && hit2));
    assign issue     = fd_valid && !dec_stall;

    // Stall or redirect leaves a bubble
    always_ff @(posedge clk) begin
        if (!resetn || redirect) begin
            de_valid <= 1'b0;
            de_rd    <= rv_pkg::NOP_ID;
        end else if (!hold) begin
            de_valid <= issue;
            de_rd    <= issue ? dst : rv_pkg::NOP_ID;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold) begin
            de_pc         <= fd_pc;
            de_op         <= op;
            de_alu_op     <= alu_op;
            de_a          <= rd1;
            de_b          <= opb;
            de_imm        <= imm;
            de_store_data <= rd2;
        end
    end

endmodule

//--- rv_execute.sv
/*
 Execute stage with ALU, branch and jump resolution,
 redirect to fetch and decode, and the execute/result register
*/
`timescale 1ns/1ps

module rv_execute (
    input  logic             clk,
    input  logic             resetn,
    input  logic             de_valid,
    input  rv_pkg::rv_word   de_pc,
    input  rv_pkg::rv_opcode de_op,
    input  rv_pkg::rv_alu_op de_alu_op,
    input  rv_pkg::rv_word   de_a,
    input  rv_pkg::rv_word   de_b,
    input  rv_pkg::rv_word   de_imm,
    input  rv_pkg::rv_reg_id de_rd,
    input  rv_pkg::rv_word   de_store_data,
    input  logic             hold,
    output logic             redirect,
    output rv_pkg::rv_word   redirect_pc,
    output logic             ex_valid,
    output rv_pkg::rv_reg_id ex_rd,
    output rv_pkg::rv_word   ex_value,
    output logic             ex_is_load,
    output logic             ex_is_store,
    output rv_pkg::rv_word   ex_store_data
);

    rv_pkg::rv_word alu_res;
    logic is_branch;
    logic is_jal;
    logic cond;

    always_comb begin
        case (de_alu_op)
            rv_pkg::ALU_SUB:    alu_res = de_a - de_b;
            rv_pkg::ALU_AND:    alu_res = de_a & de_b;
            rv_pkg::ALU_OR:     alu_res = de_a | de_b;
            rv_pkg::ALU_XOR:    alu_res = de_a ^ de_b;
            rv_pkg::ALU_SLT:    alu_res = {31'b0, $signed(de_a) < $signed(de_b)};
            rv_pkg::ALU_PASS_B: alu_res = de_b;
            default:            alu_res = de_a + de_b;
        endcase
    end

    assign is_branch = de_valid && (de_op == rv_pkg::OP_BRANCH);
    assign is_jal    = de_valid && (de_op == rv_pkg::OP_JAL);
    // Zero difference means equal, XOR inverts the sense for BNE
    assign cond = (alu_res == '0) ^ (de_alu_op == rv_pkg::ALU_XOR);

    // Fires once, when the branch leaves execute
    assign redirect    = ((is_branch && cond) || is_jal) && !hold;
    assign redirect_pc = de_pc + de_imm;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ex_valid    <= 1'b0;
            ex_rd       <= rv_pkg::NOP_ID;
            ex_is_load  <= 1'b0;
            ex_is_store <= 1'b0;
        end else if (!hold) begin
            ex_valid    <= de_valid;
            ex_rd       <= de_valid ? de_rd : rv_pkg::NOP_ID;
            ex_is_load  <= de_valid && (de_op == rv_pkg::OP_LOAD);
            ex_is_store <= de_valid && (de_op == rv_pkg::OP_STORE);
        end
    end

    // Link value for JAL, address for loads and stores
    always_ff @(posedge clk) begin
        if (!hold) begin
            ex_value      <= is_jal ? de_pc + 32'd4 : alu_res;
            ex_store_data <= de_store_data;
        end
    end

endmodule

//--- rv_result.sv
/*
 Result stage with data memory request/done handshake
 and register file write-back
*/
`timescale 1ns/1ps

module rv_result (
    input  logic             clk,
    input  logic             resetn,
    input  logic             ex_valid,
    input  rv_pkg::rv_reg_id ex_rd,
    input  rv_pkg::rv_word   ex_value,
    input  logic             ex_is_load,
    input  logic             ex_is_store,
    input  rv_pkg::rv_word   ex_store_data,
    output logic             data_req,
    output logic             data_we,
    output rv_pkg::rv_word   data_addr,
    output rv_pkg::rv_word   data_wdata,
    input  logic             data_done,
    input  rv_pkg::rv_word   data_rdata,
    output logic             mem_busy,
    output logic             wb_en,
    output rv_pkg::rv_reg_id wb_rd,
    output rv_pkg::rv_word   wb_data
);

    logic access;
    logic done;

    assign access = ex_valid && (ex_is_load || ex_is_store);
    assign done   = data_req && data_done;

    // Request opens the cycle after the access arrives
    // and closes after done
    always_ff @(posedge clk) begin
        if (!resetn)
            data_req <= 1'b0;
        else
            data_req <= access && !done;
    end

    // Execute/result register is stable while held
    assign data_we    = ex_is_store;
    assign data_addr  = ex_value;
    assign data_wdata = ex_store_data;

    // Upstream frozen until the access completes
    assign mem_busy = access && !done;

    // Loads write on done, ALU results on arrival
    assign wb_en   = ex_valid && (ex_rd != rv_pkg::NOP_ID) && (!ex_is_load || done);
    assign wb_rd   = ex_rd;
    assign wb_data = ex_is_load ? data_rdata : ex_value;

endmodule

//--- rv_core.sv
/*
 RV32I core top level
 Fetch, decode, execute and result stages around the register file
*/
`timescale 1ns/1ps

module rv_core (
    input  logic           clk,
    input  logic           resetn,
    output logic           instr_req,
    output rv_pkg::rv_word instr_addr,
    input  logic           instr_done,
    input  rv_pkg::rv_word instr_rdata,
    output logic           data_req,
    output logic           data_we,
    output rv_pkg::rv_word data_addr,
    output rv_pkg::rv_word data_wdata,
    input  logic           data_done,
    input  rv_pkg::rv_word data_rdata
);

    logic fd_valid, dec_stall, mem_busy, fetch_hold, redirect;
    rv_pkg::rv_word fd_pc, fd_instr, rd1, rd2, redirect_pc;
    rv_pkg::rv_reg_id rs1, rs2;
    logic de_valid;
    rv_pkg::rv_word de_pc, de_a, de_b, de_imm, de_store_data;
    rv_pkg::rv_opcode de_op;
    rv_pkg::rv_alu_op de_alu_op;
    rv_pkg::rv_reg_id de_rd, ex_rd, wb_rd;
    logic ex_valid, ex_is_load, ex_is_store, wb_en;
    rv_pkg::rv_word ex_value, ex_store_data, wb_data;

    // Fetch also waits on the decode interlock
    assign fetch_hold = dec_stall | mem_busy;

    rv_regfile u_regfile (.clk, .rs1, .rs2, .rd1, .rd2, .wb_en, .wb_rd, .wb_data);

    rv_fetch u_fetch (
        .clk, .resetn, .instr_req, .instr_addr, .instr_done, .instr_rdata,
        .hold(fetch_hold), .redirect, .redirect_pc, .fd_valid, .fd_pc, .fd_instr
    );

    rv_decode u_decode (
        .clk, .resetn, .fd_valid, .fd_pc, .fd_instr, .hold(mem_busy), .redirect,
        .rs1, .rs2, .rd1, .rd2, .ex_rd, .ex_valid, .wb_rd, .wb_en, .dec_stall,
        .de_valid, .de_pc, .de_op, .de_alu_op, .de_a, .de_b, .de_imm, .de_rd, .de_store_data
    );

    rv_execute u_execute (
        .clk, .resetn, .de_valid, .de_pc, .de_op, .de_alu_op, .de_a, .de_b, .de_imm,
        .de_rd, .de_store_data, .hold(mem_busy), .redirect, .redirect_pc,
        .ex_valid, .ex_rd, .ex_value, .ex_is_load, .ex_is_store, .ex_store_data
    );

    rv_result u_result (
        .clk, .resetn, .ex_valid, .ex_rd, .ex_value, .ex_is_load, .ex_is_store,
        .ex_store_data, .data_req, .data_we, .data_addr, .data_wdata, .data_done,
        .data_rdata, .mem_busy, .wb_en, .wb_rd, .wb_data
    );

endmodule

//--- tb_clock.sv
/*
 Testbench clock and reset generator
 Reset held low for a fixed number of cycles at start and on request
*/
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD       = 40,
    parameter int RESET_CYCLES = 4
) (
    input  logic restart,
    output logic clk,
    output logic resetn
);

    int left;

    initial begin
        clk    = 1'b0;
        resetn = 1'b0;
        left   = RESET_CYCLES;
    end

    always #(PERIOD / 2) clk = ~clk;

    // Restart reloads the count, release after the last reset cycle
    always @(posedge clk) begin
        if (restart) begin
            left   <= RESET_CYCLES;
            resetn <= 1'b0;
        end else if (left > 0) begin
            left   <= left - 1;
            resetn <= (left == 1);
        end
    end

endmodule

//--- tb_core.sv
/*
 Testbench for the RV32I core
 Instruction and data memory models with random latency,
 directed program tests, store compare tasks, watchdog and summary
*/
`timescale 1ns/1ps

module tb_core;

    localparam int CLK_PERIOD = 40;
    // Last store of every program goes here
    localparam int MARKER = 'h3FC;
    // 5 programs x 32 instruction slots x 10 worst-case cycles each, doubled
    localparam int WATCHDOG_NS = 5 * 32 * 10 * CLK_PERIOD * 2;

    logic clk;
    logic resetn;
    logic restart;
    logic instr_req, instr_done, data_req, data_we, data_done;
    rv_pkg::rv_word instr_addr, instr_rdata, data_addr, data_wdata, data_rdata;

    rv_pkg::rv_word imem [256];
    rv_pkg::rv_word dmem [256];
    // Stores the running program must make, in order
    rv_pkg::rv_word exp_addr [$];
    rv_pkg::rv_word exp_data [$];
    int ptr;
    int errors;
    int stores;
    logic prog_done;

    tb_clock #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(4)) u_clock (.restart, .clk, .resetn);

    rv_core UUT (
        .clk, .resetn, .instr_req, .instr_addr, .instr_done, .instr_rdata,
        .data_req, .data_we, .data_addr, .data_wdata, .data_done, .data_rdata
    );

    // RV32I encoders, one per instruction format
    function automatic rv_pkg::rv_word imm_op(input rv_pkg::rv_funct3 f3, input int rd,
                                              input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], rv_pkg::OP_IMM};
    endfunction

    function automatic rv_pkg::rv_word reg_op(input logic [6:0] f7, input rv_pkg::rv_funct3 f3,
                                              input int rd, input int rs1, input int rs2);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], rv_pkg::OP_REG};
    endfunction

    function automatic rv_pkg::rv_word lw(input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], rv_pkg::F3_WORD, rd[4:0], rv_pkg::OP_LOAD};
    endfunction

    function automatic rv_pkg::rv_word sw(input int rs2, input int rs1, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], rv_pkg::F3_WORD, imm[4:0], rv_pkg::OP_STORE};
    endfunction

    function automatic rv_pkg::rv_word lui(input int rd, input int imm20);
        return {imm20[19:0], rd[4:0], rv_pkg::OP_LUI};
    endfunction

    // Offsets in bytes, relative to the branch itself
    function automatic rv_pkg::rv_word branch(input rv_pkg::rv_funct3 f3, input int rs1,
                                              input int rs2, input int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11],
                rv_pkg::OP_BRANCH};
    endfunction

    function automatic rv_pkg::rv_word jal(input int rd, input int off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], rv_pkg::OP_JAL};
    endfunction

    task automatic check_addr(input rv_pkg::rv_word got, input rv_pkg::rv_word exp);
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: store address %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic check_word(input rv_pkg::rv_word got, input rv_pkg::rv_word exp);
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: store data %h, expected %h", $time, got, exp);
        end
    endtask

    // Marker store ends the program, all others are compared in order
    task automatic note_store(input rv_pkg::rv_word addr, input rv_pkg::rv_word data);
        if (addr == MARKER) begin
            prog_done = 1'b1;
        end else if (exp_addr.size() == 0) begin
            errors++;
            $display("Unexpected store of %h to address %h at %0t", data, addr, $time);
        end else begin
            check_addr(addr, exp_addr.pop_front());
            check_word(data, exp_data.pop_front());
            stores++;
        end
    endtask

    // Instruction port, done 1 to 4 cycles after the request
    task automatic serve_instr();
        int left;
        instr_done  = 1'b0;
        instr_rdata = '0;
        left        = -1;
        forever begin
            @(posedge clk);
            if (!resetn || instr_done || !instr_req) begin
                instr_done <= 1'b0;
                left = -1;
            end else begin
                if (left < 0)
                    left = $urandom % 4;
                if (left == 0) begin
                    instr_done  <= 1'b1;
                    instr_rdata <= imem[instr_addr[9:2]];
                end
                left = left - 1;
            end
        end
    endtask

    // Data port, same timing, stores checked on completion
    task automatic serve_data();
        int left;
        data_done  = 1'b0;
        data_rdata = '0;
        left       = -1;
        forever begin
            @(posedge clk);
            if (!resetn || data_done || !data_req) begin
                data_done <= 1'b0;
                left = -1;
            end else begin
                if (left < 0)
                    left = $urandom % 4;
                if (left == 0) begin
                    data_done <= 1'b1;
                    if (data_we) begin
                        dmem[data_addr[9:2]] <= data_wdata;
                        note_store(data_addr, data_wdata);
                    end else begin
                        data_rdata <= dmem[data_addr[9:2]];
                    end
                end
                left = left - 1;
            end
        end
    endtask

    task automatic put(input rv_pkg::rv_word w);
        imem[ptr] = w;
        ptr++;
    endtask

    task automatic expect_store(input int addr, input rv_pkg::rv_word data);
        exp_addr.push_back(rv_pkg::rv_word'(addr));
        exp_data.push_back(data);
    endtask

    // Store of a register to an absolute address
    task automatic store_check(input int rs, input int addr, input rv_pkg::rv_word data);
        put(sw(rs, 0, addr));
        expect_store(addr, data);
    endtask

    // Core held in reset while the memory image is rebuilt
    task automatic begin_prog();
        restart <= 1'b1;
        wait (!resetn);
        ptr = 0;
        // No-ops whose immediate is the word index
        for (int i = 0; i < 256; i++)
            imem[i] = imm_op(rv_pkg::F3_ADD, 0, 0, i);
        exp_addr.delete();
        exp_data.delete();
        prog_done = 1'b0;
    endtask

    task automatic run_prog(input string name);
        put(sw(0, 0, MARKER));
        // Park on a jump to itself
        put(jal(0, 0));
        @(posedge clk);
        restart <= 1'b0;
        wait (prog_done);
        if (exp_addr.size() != 0) begin
            errors++;
            $display("%s: %0d expected stores never happened", name, exp_addr.size());
        end
        $display("%s program finished at %0t", name, $time);
    endtask

    task automatic alu_ops();
        rv_pkg::rv_word a, b;
        a = 32'd90;
        // -51
        b = 32'hFFFF_FFCD;
        begin_prog();
        put(imm_op(rv_pkg::F3_ADD, 1, 0, 90));
        put(imm_op(rv_pkg::F3_ADD, 2, 0, -51));
        put(reg_op(7'h00, rv_pkg::F3_ADD, 3, 1, 2));
        put(reg_op(7'h20, rv_pkg::F3_ADD, 4, 1, 2));
        put(reg_op(7'h00, rv_pkg::F3_AND, 5, 1, 2));
        put(reg_op(7'h00, rv_pkg::F3_OR, 6, 1, 2));
        put(reg_op(7'h00, rv_pkg::F3_XOR, 7, 1, 2));
        put(reg_op(7'h00, rv_pkg::F3_SLT, 8, 2, 1));
        put(reg_op(7'h00, rv_pkg::F3_SLT, 9, 1, 2));
        put(lui(10, 'hABCDE));
        put(imm_op(rv_pkg::F3_XOR, 11, 1, 'h0F3));
        put(imm_op(rv_pkg::F3_OR, 12, 2, 'h700));
        put(imm_op(rv_pkg::F3_AND, 13, 2, -256));
        store_check(3, 'h100, a + b);
        store_check(4, 'h104, a - b);
        store_check(5, 'h108, a & b);
        store_check(6, 'h10C, a | b);
        store_check(7, 'h110, a ^ b);
        // Signed compare, -51 < 90
        store_check(8, 'h114, 32'd1);
        store_check(9, 'h118, 32'd0);
        store_check(10, 'h11C, 32'hABCD_E000);
        store_check(11, 'h120, a ^ 32'h0000_00F3);
        store_check(12, 'h124, b | 32'h0000_0700);
        // Immediate sign-extended from bit 11
        store_check(13, 'h128, b & 32'hFFFF_FF00);
        run_prog("ALU");
    endtask

    task automatic raw_chains();
        rv_pkg::rv_word r1, r2, r3, r4, r5, r6, r7;
        r1 = 32'd1;
        r2 = r1 + r1;
        r3 = r2 + r1;
        r4 = r3 + r2;
        r5 = r4 + r3;
        r6 = (r5 + 32'd100) + (r5 + 32'd100);
        r7 = r6 - r5;
        begin_prog();
        put(imm_op(rv_pkg::F3_ADD, 1, 0, 1));
        put(reg_op(7'h00, rv_pkg::F3_ADD, 2, 1, 1));
        put(reg_op(7'h00, rv_pkg::F3_ADD, 3, 2, 1));
        put(reg_op(7'h00, rv_pkg::F3_ADD, 4, 3, 2));
        put(reg_op(7'h00, rv_pkg::F3_ADD, 5, 4, 3));
        put(imm_op(rv_pkg::F3_ADD, 6, 5, 100));
        // Both sources are the previous result
        put(reg_op(7'h00, rv_pkg::F3_ADD, 6, 6, 6));
        put(reg_op(7'h20, rv_pkg::F3_ADD, 7, 6, 5));
        store_check(7, 'h140, r7);
        store_check(4, 'h144, r4);
        store_check(5, 'h148, r5);
        store_check(6, 'h14C, r6);
        run_prog("RAW chain");
    endtask

    task automatic load_store();
        rv_pkg::rv_word v;
        v = 32'h1234_5678;
        begin_prog();
        put(lui(1, 'h12345));
        put(imm_op(rv_pkg::F3_ADD, 1, 1, 'h678));
        store_check(1, 'h180, v);
        // Load followed by a dependent add
        put(lw(2, 0, 'h180));
        put(imm_op(rv_pkg::F3_ADD, 2, 2, 1));
        store_check(2, 'h184, v + 32'd1);
        put(lw(3, 0, 'h184));
        put(lw(4, 0, 'h180));
        put(reg_op(7'h20, rv_pkg::F3_ADD, 5, 3, 4));
        store_check(5, 'h188, 32'd1);
        // Base register plus positive and negative offsets
        put(imm_op(rv_pkg::F3_ADD, 6, 0, 'h200));
        put(sw(2, 6, 8));
        expect_store('h208, v + 32'd1);
        put(lw(7, 6, 8));
        put(sw(7, 6, -4));
        expect_store('h1FC, v + 32'd1);
        run_prog("Load/store");
    endtask

    task automatic control_flow();
        rv_pkg::rv_word link;
        begin_prog();
        put(imm_op(rv_pkg::F3_ADD, 1, 0, 7));
        put(imm_op(rv_pkg::F3_ADD, 2, 0, 7));
        put(imm_op(rv_pkg::F3_ADD, 3, 0, 9));
        // Taken BEQ over two stores
        put(branch(rv_pkg::F3_BEQ, 1, 2, 12));
        put(sw(1, 0, 'h1C0));
        put(sw(2, 0, 'h1C4));
        put(branch(rv_pkg::F3_BNE, 1, 2, 8));
        store_check(3, 'h1C8, 32'd9);
        put(branch(rv_pkg::F3_BNE, 1, 3, 8));
        put(sw(1, 0, 'h1CC));
        link = rv_pkg::rv_word'(4 * ptr + 4);
        put(jal(5, 12));
        put(sw(1, 0, 'h1D0));
        put(sw(2, 0, 'h1D4));
        store_check(5, 'h1D8, link);
        put(branch(rv_pkg::F3_BEQ, 1, 3, 8));
        store_check(1, 'h1DC, 32'd7);
        // Three passes of a backward loop adding 5
        put(imm_op(rv_pkg::F3_ADD, 4, 0, 3));
        put(imm_op(rv_pkg::F3_ADD, 6, 0, 0));
        put(imm_op(rv_pkg::F3_ADD, 6, 6, 5));
        put(imm_op(rv_pkg::F3_ADD, 4, 4, -1));
        put(branch(rv_pkg::F3_BNE, 4, 0, -8));
        store_check(6, 'h1E0, 32'd15);
        run_prog("Branch/jump");
    endtask

    task automatic zero_reg();
        begin_prog();
        put(imm_op(rv_pkg::F3_ADD, 0, 0, 55));
        put(imm_op(rv_pkg::F3_ADD, 1, 0, 11));
        put(reg_op(7'h00, rv_pkg::F3_ADD, 0, 1, 1));
        put(lui(0, 'hFFFFF));
        store_check(0, 'h1F0, 32'd0);
        put(reg_op(7'h00, rv_pkg::F3_ADD, 2, 0, 1));
        store_check(2, 'h1F4, 32'd11);
        put(imm_op(rv_pkg::F3_OR, 3, 0, -1));
        store_check(3, 'h1F8, 32'hFFFF_FFFF);
        run_prog("Register zero");
    endtask

    initial begin
        restart   = 1'b1;
        errors    = 0;
        stores    = 0;
        prog_done = 1'b0;
        void'($urandom(68));
        for (int i = 0; i < 256; i++)
            dmem[i] = 32'hDA7A_0000 + i;
        // Memory models inherit the seeded generator
        fork
            serve_instr();
            serve_data();
        join_none
        alu_ops();
        raw_chains();
        load_store();
        control_flow();
        zero_reg();
        $display("Stores checked: %0d, errors: %0d", stores, errors);
        if (errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: programs did not reach their marker store within %0d ns",
                 WATCHDOG_NS);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

//--- flist.f
rv_pkg.sv
rv_regfile.sv
rv_fetch.sv
rv_decode.sv
rv_execute.sv
rv_result.sv
rv_core.sv
tb_clock.sv
tb_core.sv
